//--- hw/bpu_cfg_pkg.sv
// Architecture constants shared by the branch prediction front end

package bpu_cfg_pkg;

  // ------------------------------------------------
  // Address layout
  // ------------------------------------------------

  // Width of every fetch and target address
  parameter int unsigned XLEN = 32;

  // Low address bits ignored by the tables
  // Fixed at 2, no compressed instructions
  parameter int unsigned OFFSET = 2;

  // Size of one instruction in bytes, sequential step of the pc
  parameter int unsigned INSTR_BYTES = 1 << OFFSET;

endpackage : bpu_cfg_pkg

//--- hw/bpu_types_pkg.sv
// Shared records and codes for predictions, resolutions and counters

package bpu_types_pkg;

  import bpu_cfg_pkg::*;

  // ------------------------------------------------
  // Records that travel between blocks
  // ------------------------------------------------

  // One fetched instruction and what was predicted for it
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic            btb_hit;
    logic            taken;    // Hit and counter both say taken
    logic [XLEN-1:0] next_pc;
  } prediction_t;

  // Outcome reported by execution for the oldest instruction
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] target;
    logic            taken;
    logic            is_branch;  // Any control transfer
  } resolution_t;

  // Training request sent to the BTB and the counter table
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic            taken;
    logic            del_entry;  // Drop a stale BTB row
    logic [XLEN-1:0] target;
  } bht_update_t;

  // ------------------------------------------------
  // Codes
  // ------------------------------------------------

  // Two-bit direction counter, upper bit is the prediction
  typedef enum logic [1:0] {
    ctr_strong_nt = 2'b00,
    ctr_weak_nt   = 2'b01,
    ctr_weak_t    = 2'b10,
    ctr_strong_t  = 2'b11
  } ctr_state_e;

  // Result of comparing a resolution with its prediction
  typedef enum logic [1:0] {
    res_correct  = 2'b00,
    res_dir_miss = 2'b01,
    res_tgt_miss = 2'b10
  } res_outcome_e;

endpackage : bpu_types_pkg

//--- hw/btb.sv
// Direct-mapped branch target buffer with tag compare, insert, delete and flush
`timescale 1ns/100ps

module btb #(
  parameter int unsigned BTB_BITS = 4
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           flush_i,
  input  logic [bpu_cfg_pkg::XLEN-1:0]   pc_i,
  input  bpu_types_pkg::bht_update_t     upd_i,
  output logic                           hit_o,
  output logic [bpu_cfg_pkg::XLEN-1:0]   target_o
);

  import bpu_cfg_pkg::*;

  localparam int unsigned BTB_ROWS = 1 << BTB_BITS;
  localparam int unsigned TAG_W    = XLEN - BTB_BITS - OFFSET;
  localparam int unsigned TGT_W    = XLEN - OFFSET;

  // Row storage, valid bits apart from the payload
  logic [BTB_ROWS-1:0] valid_q;
  logic [TAG_W-1:0]    tag_q [BTB_ROWS];
  logic [TGT_W-1:0]    tgt_q [BTB_ROWS];

  logic [BTB_BITS-1:0] rd_idx;
  logic [TAG_W-1:0]    rd_tag;
  logic [BTB_BITS-1:0] wr_idx;
  logic [TAG_W-1:0]    wr_tag;
  logic                do_insert;

  // ------------------------------------------------
  // Write side, driven by the resolver
  // ------------------------------------------------

  // Row index sits right above the instruction offset
  assign wr_idx = upd_i.pc[BTB_BITS+OFFSET-1:OFFSET];
  assign wr_tag = upd_i.pc[XLEN-1:BTB_BITS+OFFSET];

  // Only taken transfers earn a row
  assign do_insert = upd_i.valid & ~upd_i.del_entry & upd_i.taken;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (flush_i) begin
      // External flush drops every row at once
      valid_q <= '0;
    end else if (upd_i.valid) begin
      if (upd_i.del_entry) begin
        valid_q[wr_idx] <= 1'b0;
      end else if (upd_i.taken) begin
        valid_q[wr_idx] <= 1'b1;
      end
    end
  end

  // Tag and target, low offset bits are always zero
  always_ff @(posedge clk_i) begin
    if (do_insert) begin
      tag_q[wr_idx] <= wr_tag;
      tgt_q[wr_idx] <= upd_i.target[XLEN-1:OFFSET];
    end
  end

  // ------------------------------------------------
  // Read side, combinational lookup
  // ------------------------------------------------

  assign rd_idx = pc_i[BTB_BITS+OFFSET-1:OFFSET];
  assign rd_tag = pc_i[XLEN-1:BTB_BITS+OFFSET];

  // Hit needs a live row with a matching tag
  assign hit_o    = valid_q[rd_idx] & (tag_q[rd_idx] == rd_tag);
  assign target_o = {tgt_q[rd_idx], {OFFSET{1'b0}}};

endmodule : btb

//--- hw/bht.sv
// Table of two-bit saturating direction counters indexed by fetch address
`timescale 1ns/100ps

module bht #(
  parameter int unsigned BHT_BITS = 5
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           flush_i,
  input  logic [bpu_cfg_pkg::XLEN-1:0]   pc_i,
  input  bpu_types_pkg::bht_update_t     upd_i,
  output logic                           taken_o
);

  import bpu_cfg_pkg::*;
  import bpu_types_pkg::*;

  localparam int unsigned BHT_ROWS = 1 << BHT_BITS;

  ctr_state_e          ctr_q [BHT_ROWS];
  logic [BHT_BITS-1:0] rd_idx;
  logic [BHT_BITS-1:0] wr_idx;

  // One saturating step toward the actual direction
  function automatic ctr_state_e step_ctr(ctr_state_e cur, logic taken);
    ctr_state_e nxt;
    nxt = cur;
    case (cur)
      ctr_strong_nt: nxt = taken ? ctr_weak_nt  : ctr_strong_nt;
      ctr_weak_nt:   nxt = taken ? ctr_weak_t   : ctr_strong_nt;
      ctr_weak_t:    nxt = taken ? ctr_strong_t : ctr_weak_nt;
      ctr_strong_t:  nxt = taken ? ctr_strong_t : ctr_weak_t;
      default:       nxt = ctr_weak_nt;
    endcase
    return nxt;
  endfunction

  // ------------------------------------------------
  // Counter array
  // ------------------------------------------------

  assign wr_idx = upd_i.pc[BHT_BITS+OFFSET-1:OFFSET];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < BHT_ROWS; i++) begin
        ctr_q[i] <= ctr_weak_nt;
      end
    end else if (flush_i) begin
      // Flush forgets all training
      for (int i = 0; i < BHT_ROWS; i++) begin
        ctr_q[i] <= ctr_weak_nt;
      end
    end else if (upd_i.valid) begin
      ctr_q[wr_idx] <= step_ctr(ctr_q[wr_idx], upd_i.taken);
    end
  end

  // ------------------------------------------------
  // Lookup
  // ------------------------------------------------

  assign rd_idx = pc_i[BHT_BITS+OFFSET-1:OFFSET];

  // Upper counter bit gives the direction
  assign taken_o = ctr_q[rd_idx][1];

endmodule : bht

//--- hw/fetch_pc_gen.sv
// Fetch address generator that picks the next pc from predictions, redirects and stalls
`timescale 1ns/100ps

module fetch_pc_gen #(
  parameter logic [bpu_cfg_pkg::XLEN-1:0] BOOT_PC = 32'h100
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           flush_i,
  input  logic                           fetch_ready_i,
  input  logic                           fifo_full_i,
  input  logic                           btb_hit_i,
  input  logic [bpu_cfg_pkg::XLEN-1:0]   btb_target_i,
  input  logic                           bht_taken_i,
  input  logic                           redirect_i,
  input  logic [bpu_cfg_pkg::XLEN-1:0]   redirect_pc_i,
  output logic [bpu_cfg_pkg::XLEN-1:0]   fetch_pc_o,
  output logic                           fetch_valid_o,
  output logic                           push_o,
  output bpu_types_pkg::prediction_t     pred_o
);

  import bpu_cfg_pkg::*;

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] seq_pc;
  logic [XLEN-1:0] pred_pc;
  logic            pred_taken;

  // ------------------------------------------------
  // Next address prediction
  // ------------------------------------------------

  assign seq_pc = pc_q + XLEN'(INSTR_BYTES);

  // Jump only when the BTB knows a target and the counter agrees
  assign pred_taken = btb_hit_i & bht_taken_i;
  assign pred_pc    = pred_taken ? btb_target_i : seq_pc;

  // ------------------------------------------------
  // Handshake
  // ------------------------------------------------

  // No fetch into a full queue, during a flush, or on the wrong path
  // of a redirect that is being taken this cycle
  assign fetch_valid_o = ~fifo_full_i & ~flush_i & ~redirect_i;
  assign push_o        = fetch_valid_o & fetch_ready_i;

  // Record stored per fetched instruction
  assign pred_o.pc      = pc_q;
  assign pred_o.btb_hit = btb_hit_i;
  assign pred_o.taken   = pred_taken;
  assign pred_o.next_pc = pred_pc;

  // ------------------------------------------------
  // Pc register
  // ------------------------------------------------

  // Priority: flush, redirect, fetch, hold
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= BOOT_PC;
    end else if (flush_i) begin
      pc_q <= BOOT_PC;
    end else if (redirect_i) begin
      pc_q <= redirect_pc_i;
    end else if (push_o) begin
      pc_q <= pred_pc;
    end
  end

  assign fetch_pc_o = pc_q;

endmodule : fetch_pc_gen

//--- hw/pred_fifo.sv
// Circular queue of in-flight prediction records with full, empty and clear
`timescale 1ns/100ps

module pred_fifo #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        clear_i,
  input  logic                        push_i,
  input  bpu_types_pkg::prediction_t  data_i,
  input  logic                        pop_i,
  output bpu_types_pkg::prediction_t  head_o,
  output logic                        full_o,
  output logic                        empty_o
);

  import bpu_types_pkg::*;

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  prediction_t      mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  // Pointer advance with wrap for any depth
  function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    nxt = (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    return nxt;
  endfunction

  // Overflow and underflow are blocked here
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // ------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      // Misprediction or flush, everything pending is stale
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign head_o  = mem_q[rd_ptr_q];
  assign full_o  = (count_q == CNT_W'(FIFO_DEPTH));
  assign empty_o = (count_q == '0);

endmodule : pred_fifo

//--- hw/branch_resolver.sv
// Resolver that checks the oldest prediction against execution and drives training
`timescale 1ns/100ps

module branch_resolver (
  input  logic                           exe_valid_i,
  input  bpu_types_pkg::resolution_t     exe_res_i,
  input  bpu_types_pkg::prediction_t     head_i,
  output logic                           pop_o,
  output bpu_types_pkg::bht_update_t     upd_o,
  output logic                           mispredict_o,
  output logic [bpu_cfg_pkg::XLEN-1:0]   redirect_pc_o
);

  import bpu_cfg_pkg::*;
  import bpu_types_pkg::*;

  res_outcome_e outcome;
  logic         stale_hit;

  // ------------------------------------------------
  // Classification
  // ------------------------------------------------

  always_comb begin
    if (head_i.taken != exe_res_i.taken) begin
      outcome = res_dir_miss;
    end else if (exe_res_i.taken && (head_i.next_pc != exe_res_i.target)) begin
      // Right direction, wrong place
      outcome = res_tgt_miss;
    end else begin
      outcome = res_correct;
    end
  end

  // Execution reports the oldest entry, so every strobe retires the head
  assign pop_o = exe_valid_i;

  assign mispredict_o = exe_valid_i & (outcome != res_correct);

  // Fetch restarts on the real path
  assign redirect_pc_o = exe_res_i.taken ? exe_res_i.target
                                         : exe_res_i.pc + XLEN'(INSTR_BYTES);

  // ------------------------------------------------
  // Training request
  // ------------------------------------------------

  // BTB row that now points at something that is not a transfer
  assign stale_hit = head_i.btb_hit & ~exe_res_i.is_branch;

  // Branches train both tables
  // a stale row is dropped and its counter moves toward not taken
  assign upd_o.valid     = exe_valid_i & (exe_res_i.is_branch | stale_hit);
  assign upd_o.pc        = exe_res_i.pc;
  assign upd_o.taken     = exe_res_i.taken;
  assign upd_o.del_entry = stale_hit;
  assign upd_o.target    = exe_res_i.target;

endmodule : branch_resolver

//--- hw/branch_pred_unit.sv
// Top level of the branch prediction front end around fetch, queue and resolver
`timescale 1ns/100ps

module branch_pred_unit #(
  parameter int unsigned                  BTB_BITS   = 4,
  parameter int unsigned                  BHT_BITS   = 5,
  parameter int unsigned                  FIFO_DEPTH = 4,
  parameter logic [bpu_cfg_pkg::XLEN-1:0] BOOT_PC    = 32'h100
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           flush_i,
  input  logic                           fetch_ready_i,
  input  logic                           exe_valid_i,
  input  bpu_types_pkg::resolution_t     exe_res_i,
  output logic [bpu_cfg_pkg::XLEN-1:0]   fetch_pc_o,
  output logic                           fetch_valid_o,
  output logic                           mispredict_o
);

  import bpu_cfg_pkg::*;
  import bpu_types_pkg::*;

  // ------------------------------------------------
  // Internal nets
  // ------------------------------------------------

  // Lookup answers for the current fetch pc
  logic            btb_hit;
  logic [XLEN-1:0] btb_target;
  logic            bht_taken;

  // Queue traffic
  prediction_t     pred;
  prediction_t     head;
  logic            push;
  logic            pop;
  logic            fifo_full;
  logic            fifo_empty;  // Exposed here for the bound assertions
  logic            fifo_clear;

  // Resolver results
  bht_update_t     upd;
  logic [XLEN-1:0] redirect_pc;

  // Pending records are wrong path after a flush or a misprediction
  assign fifo_clear = flush_i | mispredict_o;

  fetch_pc_gen #(.BOOT_PC(BOOT_PC)) u_fetch_pc_gen (
    .clk_i, .rst_n_i, .flush_i, .fetch_ready_i,
    .fifo_full_i  (fifo_full),
    .btb_hit_i    (btb_hit),
    .btb_target_i (btb_target),
    .bht_taken_i  (bht_taken),
    .redirect_i   (mispredict_o),
    .redirect_pc_i(redirect_pc),
    .fetch_pc_o, .fetch_valid_o,
    .push_o       (push),
    .pred_o       (pred)
  );

  btb #(.BTB_BITS(BTB_BITS)) u_btb (
    .clk_i, .rst_n_i, .flush_i,
    .pc_i(fetch_pc_o), .upd_i(upd), .hit_o(btb_hit), .target_o(btb_target)
  );

  bht #(.BHT_BITS(BHT_BITS)) u_bht (
    .clk_i, .rst_n_i, .flush_i,
    .pc_i(fetch_pc_o), .upd_i(upd), .taken_o(bht_taken)
  );

  pred_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_pred_fifo (
    .clk_i, .rst_n_i,
    .clear_i(fifo_clear), .push_i(push), .data_i(pred), .pop_i(pop),
    .head_o(head), .full_o(fifo_full), .empty_o(fifo_empty)
  );

  branch_resolver u_branch_resolver (
    .exe_valid_i, .exe_res_i,
    .head_i(head), .pop_o(pop), .upd_o(upd),
    .mispredict_o, .redirect_pc_o(redirect_pc)
  );

endmodule : branch_pred_unit

//--- verification/bpu_checker.sv
// Concurrent assertions on the fetch, redirect and queue rules of the prediction front end
`timescale 1ns/100ps

module bpu_checker #(
  parameter logic [bpu_cfg_pkg::XLEN-1:0] BOOT_PC    = 32'h100,
  parameter int unsigned                  FIFO_DEPTH = 4
) (
  input logic                         clk_i,
  input logic                         rst_n_i,
  input logic                         flush_i,
  input logic                         fetch_ready_i,
  input logic                         exe_valid_i,
  input bpu_types_pkg::resolution_t   exe_res_i,
  input logic [bpu_cfg_pkg::XLEN-1:0] fetch_pc_i,
  input logic                         fetch_valid_i,
  input logic                         mispredict_i,
  input logic                         push_i,
  input logic                         pred_taken_i,
  input logic [bpu_cfg_pkg::XLEN-1:0] btb_target_i,
  input logic                         fifo_empty_i
);

  import bpu_cfg_pkg::*;

  // Number of failed assertions, watched by the testbench
  int unsigned     fail_count = 0;
  logic [XLEN-1:0] corrected_pc;
  // Instructions fetched and not yet resolved
  int              occupancy;

  // Real path after a resolution, one instruction is 4 bytes
  assign corrected_pc = exe_res_i.taken ? exe_res_i.target : exe_res_i.pc + XLEN'(4);

  // Fetches add a record, resolutions retire one
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      occupancy <= 0;
    end else if (flush_i || mispredict_i) begin
      // Flush and redirect drop every pending record
      occupancy <= 0;
    end else begin
      occupancy <= occupancy + int'(push_i) - int'(exe_valid_i);
    end
  end

  // --------------------------------------------------
  // Boot address and idle resolver
  // --------------------------------------------------

  boot_after_reset_a: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> (fetch_pc_i == BOOT_PC) && fetch_valid_i)
    else begin
      $error("fetch pc is not the boot pc or fetch is not valid after reset");
      fail_count++;
    end

  boot_after_flush_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |=> fetch_pc_i == BOOT_PC)
    else begin
      $error("fetch pc is not the boot pc one cycle after flush");
      fail_count++;
    end

  // No redirect without a resolution
  no_spurious_miss_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !exe_valid_i |-> !mispredict_i)
    else begin
      $error("mispredict pulsed without an execution strobe");
      fail_count++;
    end

  // Execution only reports instructions that are still queued
  exe_needs_entry_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    exe_valid_i |-> !fifo_empty_i)
    else begin
      $error("execution strobe arrived while the queue was empty");
      fail_count++;
    end

  // --------------------------------------------------
  // Next fetch address
  // --------------------------------------------------

  seq_step_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i && !pred_taken_i |=> fetch_pc_i == $past(fetch_pc_i) + XLEN'(4))
    else begin
      $error("fetch pc did not step by one instruction after a fetch");
      fail_count++;
    end

  taken_step_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i && pred_taken_i |=> fetch_pc_i == $past(btb_target_i))
    else begin
      $error("fetch pc did not follow the predicted target");
      fail_count++;
    end

  // Stalled fetch keeps its address
  stall_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !fetch_ready_i && !mispredict_i && !flush_i |=> $stable(fetch_pc_i))
    else begin
      $error("fetch pc moved while fetch was stalled");
      fail_count++;
    end

  redirect_pc_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mispredict_i && !flush_i |=> fetch_pc_i == $past(corrected_pc))
    else begin
      $error("fetch pc after a misprediction is not the corrected pc");
      fail_count++;
    end

  // Fetch stops when FIFO_DEPTH records wait or a flush or redirect is active
  fetch_valid_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fetch_valid_i == ((occupancy < int'(FIFO_DEPTH)) && !flush_i && !mispredict_i))
    else begin
      $error("fetch valid does not match the number of pending instructions");
      fail_count++;
    end

endmodule : bpu_checker

bind branch_pred_unit bpu_checker #(
  .BOOT_PC(BOOT_PC), .FIFO_DEPTH(FIFO_DEPTH)
) u_bpu_checker (
  .clk_i, .rst_n_i, .flush_i, .fetch_ready_i, .exe_valid_i, .exe_res_i,
  .fetch_pc_i   (fetch_pc_o),
  .fetch_valid_i(fetch_valid_o),
  .mispredict_i (mispredict_o),
  .push_i       (push),
  .pred_taken_i (pred.taken),
  .btb_target_i (btb_target),
  .fifo_empty_i (fifo_empty)
);

//--- verification/tb_branch_pred_unit.sv
// Testbench for the branch prediction front end with an in-order execution model
`timescale 1ns/100ps

module tb_branch_pred_unit;

  import bpu_cfg_pkg::*;
  import bpu_types_pkg::*;

  localparam int unsigned     BTB_BITS   = 4;
  localparam int unsigned     BHT_BITS   = 5;
  localparam int unsigned     FIFO_DEPTH = 4;
  localparam logic [XLEN-1:0] BOOT_PC    = 32'h100;
  localparam int unsigned     TIMEOUT    = 200;

  // Branch table of the execution model
  localparam logic [XLEN-1:0] P_PC    = 32'h108;
  localparam logic [XLEN-1:0] T_PC    = 32'h140;
  localparam logic [XLEN-1:0] LOOP_PC = 32'h14c;
  localparam logic [XLEN-1:0] WRAP_PC = 32'h17c;
  localparam int unsigned     P_BTB_IDX = (P_PC >> OFFSET) % (1 << BTB_BITS);
  localparam int unsigned     P_BHT_IDX = (P_PC >> OFFSET) % (1 << BHT_BITS);

  logic            clk_i;
  logic            rst_n_i;
  logic            flush_i;
  logic            fetch_ready_i;
  logic            exe_valid_i;
  resolution_t     exe_res_i;
  logic [XLEN-1:0] fetch_pc_o;
  logic            fetch_valid_o;
  logic            mispredict_o;

  // Execution model, fetched pcs waiting for resolution in order
  logic [XLEN-1:0] pending [$];
  int unsigned     loop_seen;
  logic            p_trained;
  logic            fetched;
  logic [XLEN-1:0] fetched_pc;
  logic            resolved;
  logic [XLEN-1:0] resolved_pc;

  branch_pred_unit #(
    .BTB_BITS(BTB_BITS), .BHT_BITS(BHT_BITS), .FIFO_DEPTH(FIFO_DEPTH), .BOOT_PC(BOOT_PC)
  ) dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic stop_with_failure(input string why);
    $display("FAIL: see errors above");
    $fatal(1, "%s", why);
  endtask

  task automatic report_mismatch(input string name, input logic [XLEN-1:0] got,
                                 input logic [XLEN-1:0] exp);
    $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
    stop_with_failure("value mismatch");
  endtask

  task automatic check_bound_asserts();
    if (dut0.u_bpu_checker.fail_count != 0) begin
      stop_with_failure("an assertion in the bound checker failed");
    end
  endtask

  // Outcome of one instruction, loop branch falls through every fourth time
  function automatic resolution_t exe_outcome(logic [XLEN-1:0] pc, int unsigned occ);
    resolution_t res;
    res.pc        = pc;
    res.is_branch = 1'b1;
    res.taken     = 1'b1;
    res.target    = BOOT_PC;
    case (pc)
      P_PC:    res.target = T_PC;
      LOOP_PC: res.taken  = (occ % 4) != 3;
      WRAP_PC: res.taken  = 1'b1;
      default: begin
        res.is_branch = 1'b0;
        res.taken     = 1'b0;
        res.target    = pc + XLEN'(4);
      end
    endcase
    return res;
  endfunction

  // --------------------------------------------------
  // One cycle of fetch and execution traffic
  // --------------------------------------------------

  task automatic drive_cycle(input logic ready, input logic do_exe);
    @(negedge clk_i);
    check_bound_asserts();
    flush_i       = 1'b0;
    fetch_ready_i = ready;
    exe_valid_i   = 1'b0;
    resolved      = 1'b0;
    if (do_exe && (pending.size() > 0)) begin
      resolved_pc = pending.pop_front();
      exe_res_i   = exe_outcome(resolved_pc, loop_seen);
      exe_valid_i = 1'b1;
      resolved    = 1'b1;
      if (resolved_pc == LOOP_PC) begin
        loop_seen++;
      end
    end
    #1;
    // Trained branch resolving taken to its learned target
    if (resolved && p_trained && (resolved_pc == P_PC)) begin
      assert (!mispredict_o) else report_mismatch("mispredict_o", XLEN'(mispredict_o), '0);
    end
    if (resolved && (resolved_pc == P_PC)) begin
      p_trained = 1'b1;
    end
    // Wrong path work is dropped on a redirect
    if (resolved && mispredict_o) begin
      pending.delete();
    end
    fetched    = fetch_valid_o & fetch_ready_i;
    fetched_pc = fetch_pc_o;
    if (fetched) begin
      pending.push_back(fetch_pc_o);
    end
  endtask

  task automatic apply_flush();
    @(negedge clk_i);
    check_bound_asserts();
    flush_i       = 1'b1;
    fetch_ready_i = 1'b1;
    exe_valid_i   = 1'b0;
    fetched       = 1'b0;
    resolved      = 1'b0;
    p_trained     = 1'b0;
    pending.delete();
  endtask

  task automatic run_until_fetch(input logic [XLEN-1:0] pc, input logic do_exe);
    logic found;
    found = 1'b0;
    for (int n = 0; (n < TIMEOUT) && !found; n++) begin
      drive_cycle(1'b1, do_exe);
      found = fetched && (fetched_pc == pc);
    end
    if (!found) begin
      stop_with_failure("timeout waiting for a fetch of the expected pc");
    end
  endtask

  task automatic resolve_until(input logic [XLEN-1:0] pc);
    logic found;
    found = 1'b0;
    for (int n = 0; (n < TIMEOUT) && !found; n++) begin
      drive_cycle(1'b1, 1'b1);
      found = resolved && (resolved_pc == pc);
    end
    if (!found) begin
      stop_with_failure("timeout waiting for a resolution of the expected pc");
    end
  endtask

  // --------------------------------------------------
  // Directed and random sequence
  // --------------------------------------------------

  initial begin
    void'($urandom(32'h1704));
    rst_n_i       = 1'b1;
    flush_i       = 1'b0;
    fetch_ready_i = 1'b0;
    exe_valid_i   = 1'b0;
    exe_res_i     = '0;
    loop_seen     = 0;
    p_trained     = 1'b0;
    fetched       = 1'b0;
    fetched_pc    = '0;
    resolved      = 1'b0;
    resolved_pc   = '0;
    #1;
    rst_n_i = 1'b0;
    repeat (8) @(negedge clk_i);
    rst_n_i = 1'b1;
    #1;
    assert (fetch_pc_o == BOOT_PC) else report_mismatch("fetch_pc_o", fetch_pc_o, BOOT_PC);

    // Stall, then fill the queue with no resolutions
    repeat (3) drive_cycle(1'b0, 1'b0);
    assert (fetch_pc_o == BOOT_PC) else report_mismatch("fetch_pc_o", fetch_pc_o, BOOT_PC);
    for (int n = 0; (n < TIMEOUT) && fetch_valid_o; n++) begin
      drive_cycle(1'b1, 1'b0);
    end
    if (fetch_valid_o) begin
      stop_with_failure("timeout waiting for the queue to fill");
    end
    assert (pending.size() == FIFO_DEPTH)
      else report_mismatch("fetch count", XLEN'(pending.size()), XLEN'(FIFO_DEPTH));
    for (int k = 0; k < 3; k++) begin
      drive_cycle(1'b1, 1'b0);
      assert (!fetch_valid_o) else report_mismatch("fetch_valid_o", XLEN'(fetch_valid_o), '0);
    end
    // One pop reopens fetch
    drive_cycle(1'b1, 1'b1);
    drive_cycle(1'b1, 1'b0);
    assert (fetch_valid_o) else report_mismatch("fetch_valid_o", XLEN'(fetch_valid_o), 1);

    // First taken resolution of P trains both tables
    resolve_until(P_PC);
    assert (mispredict_o) else report_mismatch("mispredict_o", XLEN'(mispredict_o), 1);
    drive_cycle(1'b1, 1'b0);
    assert (fetch_pc_o == T_PC) else report_mismatch("fetch_pc_o", fetch_pc_o, T_PC);
    assert (dut0.u_bht.ctr_q[P_BHT_IDX] == ctr_weak_t)
      else report_mismatch("bht counter", XLEN'(dut0.u_bht.ctr_q[P_BHT_IDX]), XLEN'(ctr_weak_t));
    assert (dut0.u_btb.valid_q[P_BTB_IDX])
      else report_mismatch("btb valid", XLEN'(dut0.u_btb.valid_q[P_BTB_IDX]), 1);

    // Next fetch of P jumps straight to T
    run_until_fetch(P_PC, 1'b1);
    drive_cycle(1'b1, 1'b0);
    assert (fetch_pc_o == T_PC) else report_mismatch("fetch_pc_o", fetch_pc_o, T_PC);
    resolve_until(P_PC);

    // Random ready and resolution timing
    for (int k = 0; k < 160; k++) begin
      drive_cycle(($urandom % 4) != 0, ($urandom % 2) == 1);
    end

    // Flush forgets the trained entry
    apply_flush();
    drive_cycle(1'b0, 1'b0);
    assert (fetch_pc_o == BOOT_PC) else report_mismatch("fetch_pc_o", fetch_pc_o, BOOT_PC);
    assert (!dut0.u_btb.valid_q[P_BTB_IDX])
      else report_mismatch("btb valid", XLEN'(dut0.u_btb.valid_q[P_BTB_IDX]), '0);
    assert (dut0.u_bht.ctr_q[P_BHT_IDX] == ctr_weak_nt)
      else report_mismatch("bht counter", XLEN'(dut0.u_bht.ctr_q[P_BHT_IDX]), XLEN'(ctr_weak_nt));
    run_until_fetch(P_PC, 1'b0);
    drive_cycle(1'b0, 1'b0);
    assert (fetch_pc_o == P_PC + XLEN'(4))
      else report_mismatch("fetch_pc_o", fetch_pc_o, P_PC + XLEN'(4));
    drive_cycle(1'b0, 1'b0);

    @(negedge clk_i);
    if (dut0.u_bpu_checker.fail_count == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      stop_with_failure("an assertion in the bound checker failed");
    end
  end

endmodule : tb_branch_pred_unit

//--- src.f
hw/bpu_cfg_pkg.sv
hw/bpu_types_pkg.sv
hw/btb.sv
hw/bht.sv
hw/fetch_pc_gen.sv
hw/pred_fifo.sv
hw/branch_resolver.sv
hw/branch_pred_unit.sv
verification/bpu_checker.sv
verification/tb_branch_pred_unit.sv
